/* src/rv_core_pkg.sv */
// Shared widths, select codes, opcodes and pipeline structs of the RV32I core
`default_nettype none

package rv_core_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int WORD_WIDTH     = 32;
	localparam int REG_IDX_BITS   = 5;
	localparam int PC_BITS        = 12;	// 4 KiB of program space
	localparam int IMEM_ADDR_BITS = 10;
	localparam int DMEM_ADDR_BITS = 10;

	typedef logic [WORD_WIDTH-1:0]     word_t;
	typedef logic [REG_IDX_BITS-1:0]   reg_idx_t;
	typedef logic [PC_BITS-1:0]        pc_t;		// Byte address
	typedef logic [IMEM_ADDR_BITS-1:0] imem_addr_t;	// Word index
	typedef logic [DMEM_ADDR_BITS-1:0] dmem_addr_t;	// Word index

	//////////////////////////////////////////////////
	// Select codes
	//////////////////////////////////////////////////
	typedef logic [3:0] alu_op_t;
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_AND  = 4'd2;
	localparam alu_op_t ALU_OR   = 4'd3;
	localparam alu_op_t ALU_XOR  = 4'd4;
	localparam alu_op_t ALU_SLT  = 4'd5;
	localparam alu_op_t ALU_SLTU = 4'd6;
	localparam alu_op_t ALU_SLL  = 4'd7;
	localparam alu_op_t ALU_SRL  = 4'd8;
	localparam alu_op_t ALU_SRA  = 4'd9;

	typedef logic [1:0] wb_sel_t;
	localparam wb_sel_t WB_PC4  = 2'd0;
	localparam wb_sel_t WB_ALU  = 2'd1;
	localparam wb_sel_t WB_IMM  = 2'd2;
	localparam wb_sel_t WB_LOAD = 2'd3;

	// Same coding as funct3[1:0] of loads and stores
	typedef logic [1:0] mem_size_t;
	localparam mem_size_t MEM_B = 2'd0;
	localparam mem_size_t MEM_H = 2'd1;
	localparam mem_size_t MEM_W = 2'd2;

	typedef logic [1:0] fwd_sel_t;
	localparam fwd_sel_t FWD_REG = 2'd0;	// Register file value
	localparam fwd_sel_t FWD_MEM = 2'd1;	// EX/MEM result
	localparam fwd_sel_t FWD_WB  = 2'd2;	// Writeback value

	// Major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam word_t NOP_INST = 32'h0000_0013;	// addi x0, x0, 0

	//////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////
	typedef struct packed {
		alu_op_t    alu_op;
		logic       sel_pc_a;	// Operand A is the PC
		logic       sel_imm_b;	// Operand B is the immediate
		logic       is_branch;
		logic       is_jal;
		logic       is_jalr;
		logic [2:0] funct3;	// Branch condition, access size
		logic       mem_rd;
		logic       mem_wr;
		wb_sel_t    wb_sel;
		logic       rf_we;
	} ctrl_t;

	typedef struct packed {
		logic       en;
		imem_addr_t addr;
		word_t      data;
	} imem_load_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} retire_t;

	typedef struct packed {
		logic  valid;
		pc_t   pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		pc_t      pc;
		ctrl_t    ctrl;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    rs1_val;
		word_t    rs2_val;
		word_t    imm;
	} id_ex_t;

	typedef struct packed {
		logic       valid;
		pc_t        pc4;
		ctrl_t      ctrl;
		reg_idx_t   rd;
		word_t      alu_out;
		word_t      store_data;	// Already lane aligned
		logic [3:0] byte_en;	// Zero unless a valid store
		word_t      imm;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		pc_t      pc4;
		wb_sel_t  wb_sel;
		logic     rf_we;
		reg_idx_t rd;
		word_t    alu_out;
		word_t    load_data;
		word_t    imm;
	} mem_wb_t;

endpackage

`default_nettype wire

/* src/rv_fetch.sv */
// Fetch stage: PC register, instruction memory with load port, next PC
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_core_pkg::*; (
	input  wire logic       i_clk,
	input  wire logic       i_arst_n,
	input  wire imem_load_t i_imem_load,	// Written while reset is held
	input  wire logic       i_stall,		// Load-use hold
	input  wire logic       i_redirect,	// Taken branch or jump in execute
	input  wire pc_t        i_target,
	output      if_id_t     o_if
);

	word_t      imem [2**IMEM_ADDR_BITS];	// No reset on the array
	pc_t        pc_q;
	imem_addr_t fetch_idx;

	assign fetch_idx = pc_q[PC_BITS-1:2];	// Word aligned

	// Program load port
	always_ff @(posedge i_clk) begin
		if (i_imem_load.en)
			imem[i_imem_load.addr] <= i_imem_load.data;
	end

	// Next PC; redirect beats the stall
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc_q <= '0;
		end else if (i_redirect) begin
			pc_q <= i_target;
		end else if (!i_stall) begin
			pc_q <= pc_q + pc_t'(4);	// Predict not taken
		end
	end

	// Asynchronous read at the current PC
	assign o_if.valid = 1'b1;		// IF/ID reset supplies the bubbles
	assign o_if.pc    = pc_q;
	assign o_if.inst  = imem[fetch_idx];

endmodule

`default_nettype wire

/* src/rv_decoder.sv */
// Control decoder and immediate generator for RV32I
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_core_pkg::*; (
	input  wire word_t i_inst,
	output      ctrl_t o_ctrl,
	output      word_t o_imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	// ALU op from funct3, alt selects SUB or SRA
	function automatic alu_op_t alu_from_funct(logic [2:0] f3, logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Control word
	//////////////////////////////////////////////////
	always_comb begin
		o_ctrl        = '0;		// Unknown opcode writes nothing
		o_ctrl.alu_op = ALU_ADD;
		o_ctrl.wb_sel = WB_ALU;
		o_ctrl.funct3 = funct3;
		case (opcode)
			OPC_LUI: begin
				o_ctrl.wb_sel = WB_IMM;
				o_ctrl.rf_we  = 1'b1;
			end
			OPC_AUIPC: begin
				o_ctrl.sel_pc_a  = 1'b1;	// PC + imm
				o_ctrl.sel_imm_b = 1'b1;
				o_ctrl.rf_we     = 1'b1;
			end
			OPC_JAL: begin
				o_ctrl.is_jal = 1'b1;
				o_ctrl.wb_sel = WB_PC4;	// Link
				o_ctrl.rf_we  = 1'b1;
			end
			OPC_JALR: begin
				o_ctrl.is_jalr = 1'b1;
				o_ctrl.wb_sel  = WB_PC4;
				o_ctrl.rf_we   = 1'b1;
			end
			OPC_BRANCH: o_ctrl.is_branch = 1'b1;
			OPC_LOAD: begin
				o_ctrl.sel_imm_b = 1'b1;	// Address = rs1 + imm
				o_ctrl.mem_rd    = 1'b1;
				o_ctrl.wb_sel    = WB_LOAD;
				o_ctrl.rf_we     = 1'b1;
			end
			OPC_STORE: begin
				o_ctrl.sel_imm_b = 1'b1;
				o_ctrl.mem_wr    = 1'b1;
			end
			OPC_OPIMM: begin
				o_ctrl.sel_imm_b = 1'b1;
				// Only SRAI uses funct7 here
				o_ctrl.alu_op = alu_from_funct(funct3, (funct3 == 3'b101) && funct7[5]);
				o_ctrl.rf_we  = 1'b1;
			end
			OPC_OP: begin
				o_ctrl.alu_op = alu_from_funct(funct3, funct7[5]);
				o_ctrl.rf_we  = 1'b1;
			end
			default: o_ctrl.funct3 = 3'b000;
		endcase
	end

	//////////////////////////////////////////////////
	// Immediates
	//////////////////////////////////////////////////
	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC:	// U type
				o_imm = {i_inst[31:12], 12'b0};
			OPC_JAL:		// J type
				o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
					i_inst[30:21], 1'b0};
			OPC_BRANCH:		// B type
				o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
					i_inst[11:8], 1'b0};
			OPC_STORE:		// S type
				o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
			default:		// I type
				o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
		endcase
	end

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
// Register file, 31 entries plus hard-wired x0, with write-through read
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
	input  wire logic     i_clk,
	input  wire logic     i_arst_n,
	input  wire logic     i_we,
	input  wire reg_idx_t i_rd,
	input  wire word_t    i_wdata,
	input  wire reg_idx_t i_rs1,
	input  wire reg_idx_t i_rs2,
	output      word_t    o_rdata1,
	output      word_t    o_rdata2
);

	word_t regs [1:31];	// x0 has no storage

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (i_we && (i_rd != '0)) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// Same-cycle write wins, so decode sees the writeback value
	function automatic word_t read_port(reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (i_we && (idx == i_rd))
			return i_wdata;
		return regs[idx];
	endfunction

	assign o_rdata1 = read_port(i_rs1);
	assign o_rdata2 = read_port(i_rs2);

endmodule

`default_nettype wire

/* src/rv_execute.sv */
// Execute stage: operand forwarding, ALU, branch check, jump target, store lanes
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_core_pkg::*; (
	input  wire id_ex_t   i_ex,
	input  wire fwd_sel_t i_fwd_a,
	input  wire fwd_sel_t i_fwd_b,
	input  wire word_t    i_mem_value,	// Result held in EX/MEM
	input  wire word_t    i_wb_value,	// Value being written back
	output      ex_mem_t  o_mem,
	output      logic     o_redirect,
	output      pc_t      o_target
);

	word_t     fwd_a, fwd_b;		// rs1, rs2 after forwarding
	word_t     op_a, op_b;
	word_t     alu_out;
	word_t     target_sum;
	logic      taken;
	mem_size_t size;

	function automatic word_t pick(fwd_sel_t sel, word_t reg_val);
		case (sel)
			FWD_MEM: return i_mem_value;
			FWD_WB:  return i_wb_value;
			default: return reg_val;
		endcase
	endfunction

	assign fwd_a = pick(i_fwd_a, i_ex.rs1_val);
	assign fwd_b = pick(i_fwd_b, i_ex.rs2_val);
	assign op_a  = i_ex.ctrl.sel_pc_a  ? word_t'(i_ex.pc) : fwd_a;	// AUIPC
	assign op_b  = i_ex.ctrl.sel_imm_b ? i_ex.imm : fwd_b;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (i_ex.ctrl.alu_op)
			ALU_SUB:  alu_out = op_a - op_b;
			ALU_AND:  alu_out = op_a & op_b;
			ALU_OR:   alu_out = op_a | op_b;
			ALU_XOR:  alu_out = op_a ^ op_b;
			ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_out = word_t'(op_a < op_b);
			ALU_SLL:  alu_out = op_a << op_b[4:0];
			ALU_SRL:  alu_out = op_a >> op_b[4:0];
			ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
			default:  alu_out = op_a + op_b;
		endcase
	end

	// Branch conditions on the forwarded sources
	always_comb begin
		case (i_ex.ctrl.funct3)
			3'b000:  taken = (fwd_a == fwd_b);				// BEQ
			3'b001:  taken = (fwd_a != fwd_b);				// BNE
			3'b100:  taken = ($signed(fwd_a) < $signed(fwd_b));	// BLT
			3'b101:  taken = ($signed(fwd_a) >= $signed(fwd_b));	// BGE
			3'b110:  taken = (fwd_a < fwd_b);				// BLTU
			3'b111:  taken = (fwd_a >= fwd_b);				// BGEU
			default: taken = 1'b0;
		endcase
	end

	// Own adder for targets; JALR bases on rs1 and clears bit 0
	assign target_sum = (i_ex.ctrl.is_jalr ? fwd_a : word_t'(i_ex.pc)) + i_ex.imm;
	assign o_target   = {target_sum[PC_BITS-1:1], 1'b0};
	assign o_redirect = i_ex.valid &&
		((i_ex.ctrl.is_branch && taken) || i_ex.ctrl.is_jal || i_ex.ctrl.is_jalr);

	//////////////////////////////////////////////////
	// Store alignment and EX/MEM fields
	//////////////////////////////////////////////////
	assign size = mem_size_t'(i_ex.ctrl.funct3[1:0]);

	always_comb begin
		o_mem            = '0;
		o_mem.valid      = i_ex.valid;
		o_mem.pc4        = i_ex.pc + pc_t'(4);
		o_mem.ctrl       = i_ex.ctrl;
		o_mem.rd         = i_ex.rd;
		o_mem.alu_out    = alu_out;
		o_mem.imm        = i_ex.imm;
		case (size)
			MEM_B: begin
				o_mem.store_data = {4{fwd_b[7:0]}};	// Byte copied to every lane
				o_mem.byte_en    = 4'b0001 << alu_out[1:0];
			end
			MEM_H: begin
				o_mem.store_data = {2{fwd_b[15:0]}};
				o_mem.byte_en    = alu_out[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				o_mem.store_data = fwd_b;
				o_mem.byte_en    = 4'b1111;
			end
		endcase
		if (!(i_ex.valid && i_ex.ctrl.mem_wr))
			o_mem.byte_en = 4'b0000;	// Bubbles and non-stores write nothing
	end

endmodule

`default_nettype wire

/* src/rv_memory.sv */
// Data memory with byte-enable writes and registered read, plus load extension
`timescale 1ns/1ps
`default_nettype none

module rv_memory import rv_core_pkg::*; (
	input  wire logic    i_clk,
	input  wire ex_mem_t i_mem,
	output      word_t   o_load_data	// Valid in the writeback cycle
);

	word_t      dmem [2**DMEM_ADDR_BITS];
	dmem_addr_t addr;
	word_t      rd_word;		// Read side registers
	logic [1:0] rd_off;
	mem_size_t  rd_size;
	logic       rd_unsigned;
	word_t      shifted;

	assign addr = i_mem.alu_out[DMEM_ADDR_BITS+1:2];

	// Byte lanes written independently
	always_ff @(posedge i_clk) begin
		for (int b = 0; b < 4; b++) begin
			if (i_mem.byte_en[b])
				dmem[addr][8*b +: 8] <= i_mem.store_data[8*b +: 8];
		end
	end

	// Read word and access shape captured with the MEM/WB write
	always_ff @(posedge i_clk) begin
		rd_word     <= dmem[addr];
		rd_off      <= i_mem.alu_out[1:0];
		rd_size     <= mem_size_t'(i_mem.ctrl.funct3[1:0]);
		rd_unsigned <= i_mem.ctrl.funct3[2];	// LBU, LHU
	end

	//////////////////////////////////////////////////
	// Load block
	//////////////////////////////////////////////////
	assign shifted = rd_word >> {rd_off, 3'b000};	// Addressed byte to bit 0

	always_comb begin
		case (rd_size)
			MEM_B:   o_load_data = {{24{~rd_unsigned & shifted[7]}}, shifted[7:0]};
			MEM_H:   o_load_data = {{16{~rd_unsigned & shifted[15]}}, shifted[15:0]};
			default: o_load_data = rd_word;
		endcase
	end

endmodule

`default_nettype wire

/* src/rv_hazard_unit.sv */
// Forwarding selects, load-use stall and redirect flushes
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit import rv_core_pkg::*; (
	input  wire reg_idx_t i_id_rs1,
	input  wire reg_idx_t i_id_rs2,
	input  wire id_ex_t   i_ex,
	input  wire ex_mem_t  i_mem,
	input  wire mem_wb_t  i_wb,
	input  wire logic     i_redirect,
	output      fwd_sel_t o_fwd_a,
	output      fwd_sel_t o_fwd_b,
	output      logic     o_stall,		// Hold PC and IF/ID
	output      logic     o_flush_id,	// Bubble into IF/ID
	output      logic     o_flush_ex	// Bubble into ID/EX
);

	logic load_use;

	// Youngest producer first; a load in MEM has no data yet
	function automatic fwd_sel_t fwd_for(reg_idx_t src);
		if (i_mem.valid && i_mem.ctrl.rf_we && !i_mem.ctrl.mem_rd &&
			(i_mem.rd != '0) && (i_mem.rd == src))
			return FWD_MEM;
		if (i_wb.valid && i_wb.rf_we && (i_wb.rd != '0) && (i_wb.rd == src))
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign o_fwd_a = fwd_for(i_ex.rs1);
	assign o_fwd_b = fwd_for(i_ex.rs2);

	// Load in execute feeding decode, may stall on an unused field too
	assign load_use = i_ex.valid && i_ex.ctrl.mem_rd && (i_ex.rd != '0) &&
		((i_ex.rd == i_id_rs1) || (i_ex.rd == i_id_rs2));

	assign o_stall    = load_use && !i_redirect;	// Redirect kills the stalled pair
	assign o_flush_id = i_redirect;
	assign o_flush_ex = i_redirect || load_use;

endmodule

`default_nettype wire

/* src/rv_core.sv */
// Five-stage RV32I core top: pipeline registers, writeback select, retire port
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
	input  wire logic       i_clk,
	input  wire logic       i_arst_n,
	input  wire imem_load_t i_imem_load,
	output      retire_t    o_retire
);

	if_id_t   if_out, if_id_q;
	id_ex_t   id_ex_d, id_ex_q;
	ex_mem_t  ex_mem_d, ex_mem_q;
	mem_wb_t  mem_wb_d, mem_wb_q, wb;
	ctrl_t    id_ctrl;
	word_t    id_imm, rs1_val, rs2_val;
	word_t    load_data, mem_value, wb_value;
	fwd_sel_t fwd_a, fwd_b;
	logic     stall, flush_id, flush_ex, redirect;
	pc_t      target;

	// Stage result by writeback source
	function automatic word_t sel_result(wb_sel_t sel, pc_t pc4, word_t alu, word_t imm,
		word_t ld);
		case (sel)
			WB_PC4:  return word_t'(pc4);
			WB_IMM:  return imm;
			WB_LOAD: return ld;
			default: return alu;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Fetch and decode
	//////////////////////////////////////////////////
	rv_fetch u_fetch (.i_clk, .i_arst_n, .i_imem_load, .i_stall(stall),
		.i_redirect(redirect), .i_target(target), .o_if(if_out));

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			if_id_q <= '{valid: 1'b0, pc: '0, inst: NOP_INST};
		else if (flush_id)
			if_id_q <= '{valid: 1'b0, pc: '0, inst: NOP_INST};
		else if (!stall)
			if_id_q <= if_out;	// Held during load-use
	end

	rv_decoder u_decoder (.i_inst(if_id_q.inst), .o_ctrl(id_ctrl), .o_imm(id_imm));

	rv_regfile u_regfile (.i_clk, .i_arst_n, .i_we(wb.valid && wb.rf_we), .i_rd(wb.rd),
		.i_wdata(wb_value), .i_rs1(if_id_q.inst[19:15]), .i_rs2(if_id_q.inst[24:20]),
		.o_rdata1(rs1_val), .o_rdata2(rs2_val));

	always_comb begin
		id_ex_d         = '0;
		id_ex_d.valid   = if_id_q.valid;
		id_ex_d.pc      = if_id_q.pc;
		id_ex_d.ctrl    = id_ctrl;
		id_ex_d.rs1     = if_id_q.inst[19:15];
		id_ex_d.rs2     = if_id_q.inst[24:20];
		id_ex_d.rd      = if_id_q.inst[11:7];
		id_ex_d.rs1_val = rs1_val;
		id_ex_d.rs2_val = rs2_val;
		id_ex_d.imm     = id_imm;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			id_ex_q <= '0;
		else
			id_ex_q <= flush_ex ? '0 : id_ex_d;	// Bubble on redirect or stall
	end

	rv_hazard_unit u_hazard (.i_id_rs1(id_ex_d.rs1), .i_id_rs2(id_ex_d.rs2), .i_ex(id_ex_q),
		.i_mem(ex_mem_q), .i_wb(wb), .i_redirect(redirect), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
		.o_stall(stall), .o_flush_id(flush_id), .o_flush_ex(flush_ex));

	//////////////////////////////////////////////////
	// Execute, memory, writeback
	//////////////////////////////////////////////////
	// Loads never forward from MEM, so no load data here
	assign mem_value = sel_result(ex_mem_q.ctrl.wb_sel, ex_mem_q.pc4, ex_mem_q.alu_out,
		ex_mem_q.imm, '0);

	rv_execute u_execute (.i_ex(id_ex_q), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
		.i_mem_value(mem_value), .i_wb_value(wb_value), .o_mem(ex_mem_d),
		.o_redirect(redirect), .o_target(target));

	rv_memory u_memory (.i_clk, .i_mem(ex_mem_q), .o_load_data(load_data));

	always_comb begin
		mem_wb_d           = '0;
		mem_wb_d.valid     = ex_mem_q.valid;
		mem_wb_d.pc4       = ex_mem_q.pc4;
		mem_wb_d.wb_sel    = ex_mem_q.ctrl.wb_sel;
		mem_wb_d.rf_we     = ex_mem_q.ctrl.rf_we;
		mem_wb_d.rd        = ex_mem_q.rd;
		mem_wb_d.alu_out   = ex_mem_q.alu_out;
		mem_wb_d.imm       = ex_mem_q.imm;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ex_mem_q <= '0;
			mem_wb_q <= '0;
		end else begin
			ex_mem_q <= ex_mem_d;
			mem_wb_q <= mem_wb_d;
		end
	end

	// Load data comes from the memory's own read register
	always_comb begin
		wb           = mem_wb_q;
		wb.load_data = load_data;
	end

	assign wb_value = sel_result(wb.wb_sel, wb.pc4, wb.alu_out, wb.imm, wb.load_data);

	assign o_retire.valid = wb.valid && wb.rf_we && (wb.rd != '0);
	assign o_retire.rd    = wb.rd;
	assign o_retire.data  = wb_value;

endmodule

`default_nettype wire

/* dv/rv_core_assertions.sv */
// Concurrent checks on the retire port, bound into the core top level
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions import rv_core_pkg::*; (
	input wire logic    i_clk,
	input wire logic    i_arst_n,
	input wire retire_t i_retire
);

	// x0 writes are filtered before the port
	a_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_retire.valid |-> (i_retire.rd != '0))
		else $error("retire to register x0");

	a_data_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_retire.valid |-> !$isunknown(i_retire.data))
		else $error("retire data unknown");

	// Pipeline valids cleared by the asynchronous reset
	a_reset_quiet: assert property (@(posedge i_clk)
		!i_arst_n |-> !i_retire.valid)
		else $error("retire valid during reset");

endmodule

bind rv_core rv_core_assertions u_assertions (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_retire(o_retire)
);

`default_nettype wire

/* dv/rv_core_tb.sv */
// Directed testbench for the RV32I core: program loader, retire monitor, checks
// Tests cover ALU ops, forwarding, loads and stores, branches and jumps
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

	localparam word_t MARK       = 32'h0000_05a5;	// Last value written, to x31
	localparam int    WAIT_LIMIT = 2000;		// Cycles per program

	logic       clk;
	logic       arst_n;
	imem_load_t imem_load;
	retire_t    retire;

	int seed   = 89634;
	int errors = 0;
	int checks = 0;

	word_t    prog [$];		// Program image, word 0 at PC 0
	reg_idx_t want_rd [$];		// Expected retire order
	word_t    want_data [$];
	reg_idx_t got_rd [$];		// Observed retire order
	word_t    got_data [$];

	rv_core dut0 (.i_clk(clk), .i_arst_n(arst_n), .i_imem_load(imem_load), .o_retire(retire));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	// Retire monitor, sampled mid-cycle
	initial begin
		forever begin
			@(negedge clk);
			if (!arst_n && retire.valid) begin
				errors++;
				$display("ERROR: retire valid while reset is held");
			end else if (retire.valid) begin
				if ($isunknown(retire.data) || (retire.rd == '0)) begin
					errors++;
					$display("ERROR: retire to x0 or with unknown data");
				end
				got_rd.push_back(retire.rd);
				got_data.push_back(retire.data);
			end
		end
	end

	task automatic check(string name, word_t exp, word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// Instruction encoders
	//////////////////////////////////////////////////
	function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
		reg_idx_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	//////////////////////////////////////////////////
	// Program building
	//////////////////////////////////////////////////
	function automatic void emit(word_t inst);
		prog.push_back(inst);
	endfunction

	function automatic void want(reg_idx_t rd, word_t data);
		want_rd.push_back(rd);
		want_data.push_back(data);
	endfunction

	function automatic word_t here();
		return word_t'(prog.size() * 4);	// PC of the next emitted word
	endfunction

	// LUI plus ADDI, low part sign extended so the upper part rounds up
	function automatic void set_reg(reg_idx_t rd, word_t v);
		word_t hi;
		hi = (v + 32'h800) & 32'hffff_f000;
		emit(u_type(hi[31:12], rd, OPC_LUI));
		want(rd, hi);
		emit(i_type(v[11:0], rd, 3'b000, rd, OPC_OPIMM));
		want(rd, v);
	endfunction

	function automatic void reg_op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2, word_t value);
		emit(r_type(f7, rs2, rs1, f3, rd));
		want(rd, value);
	endfunction

	function automatic void imm_op(logic [11:0] imm, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, word_t value);
		emit(i_type(imm, rs1, f3, rd, OPC_OPIMM));
		want(rd, value);
	endfunction

	// Loads all use x20 as the base
	function automatic void load_op(logic [2:0] f3, logic [11:0] off, reg_idx_t rd,
		word_t value);
		emit(i_type(off, 5'd20, f3, rd, OPC_LOAD));
		want(rd, value);
	endfunction

	// RV32I branch conditions by funct3
	function automatic bit branch_taken(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic bit marker_seen();
		return (got_rd.size() > 0) && (got_rd[$] == 5'd31) && (got_data[$] == MARK);
	endfunction

	// Load under reset, run until the marker retires, compare the retire order
	task automatic run_program(string name);
		int n;
		int cycles;
		emit(i_type(MARK[11:0], 5'd0, 3'b000, 5'd31, OPC_OPIMM));
		want(5'd31, MARK);
		emit(j_type(21'd0, 5'd0));	// Park on a self loop
		emit(NOP_INST);
		emit(NOP_INST);
		@(posedge clk);
		arst_n <= 1'b0;
		got_rd.delete();
		got_data.delete();
		for (n = 0; (n < prog.size()) || (n < 8); n++) begin
			@(posedge clk);
			if (n < prog.size())
				imem_load <= '{en: 1'b1, addr: imem_addr_t'(n), data: prog[n]};
			else
				imem_load <= '0;
		end
		@(posedge clk);
		imem_load <= '0;
		arst_n    <= 1'b1;
		cycles = 0;
		while (!marker_seen() && (cycles < WAIT_LIMIT)) begin
			@(posedge clk);
			cycles++;
		end
		if (!marker_seen()) begin
			errors++;
			$display("ERROR: %s timed out waiting for its last retire", name);
		end
		check({name, " retire count"}, word_t'(want_rd.size()), word_t'(got_rd.size()));
		for (n = 0; (n < want_rd.size()) && (n < got_rd.size()); n++) begin
			check($sformatf("%s retire %0d rd", name, n), word_t'(want_rd[n]),
				word_t'(got_rd[n]));
			check($sformatf("%s retire %0d data", name, n), want_data[n], got_data[n]);
		end
		prog.delete();
		want_rd.delete();
		want_data.delete();
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////
	task automatic test_alu();
		word_t       a, b, r, ix;
		logic [11:0] imm;
		logic [4:0]  sh;
		int          round;
		for (round = 0; round < 3; round++) begin
			a = $random(seed);
			b = $random(seed);
			r = $random(seed);
			imm = r[11:0];
			sh  = r[16:12];
			ix  = {{20{imm[11]}}, imm};
			set_reg(5'd1, a);
			set_reg(5'd2, b);
			reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2, a + b);
			reg_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2, a - b);
			reg_op(7'h00, 3'b001, 5'd5, 5'd1, 5'd2, a << b[4:0]);
			reg_op(7'h00, 3'b010, 5'd6, 5'd1, 5'd2, {31'b0, $signed(a) < $signed(b)});
			reg_op(7'h00, 3'b011, 5'd7, 5'd1, 5'd2, {31'b0, a < b});
			reg_op(7'h00, 3'b100, 5'd8, 5'd1, 5'd2, a ^ b);
			reg_op(7'h00, 3'b101, 5'd9, 5'd1, 5'd2, a >> b[4:0]);
			reg_op(7'h20, 3'b101, 5'd10, 5'd1, 5'd2, $signed(a) >>> b[4:0]);
			reg_op(7'h00, 3'b110, 5'd11, 5'd1, 5'd2, a | b);
			reg_op(7'h00, 3'b111, 5'd12, 5'd1, 5'd2, a & b);
			imm_op(imm, 3'b000, 5'd13, 5'd1, a + ix);
			imm_op(imm, 3'b010, 5'd14, 5'd1, {31'b0, $signed(a) < $signed(ix)});
			imm_op(imm, 3'b011, 5'd15, 5'd1, {31'b0, a < ix});
			imm_op(imm, 3'b100, 5'd16, 5'd1, a ^ ix);
			imm_op(imm, 3'b110, 5'd17, 5'd1, a | ix);
			imm_op(imm, 3'b111, 5'd18, 5'd1, a & ix);
			imm_op({7'h00, sh}, 3'b001, 5'd19, 5'd2, b << sh);
			imm_op({7'h00, sh}, 3'b101, 5'd20, 5'd2, b >> sh);
			imm_op({7'h20, sh}, 3'b101, 5'd21, 5'd2, $signed(b) >>> sh);
		end
		run_program("alu");
	endtask

	task automatic test_forward();
		word_t v;
		v = $random(seed);
		set_reg(5'd5, v);				// ADDI takes LUI result from MEM
		reg_op(7'h00, 3'b000, 5'd6, 5'd5, 5'd5, v + v);
		reg_op(7'h00, 3'b000, 5'd7, 5'd6, 5'd5, v + v + v);	// MEM and WB
		reg_op(7'h20, 3'b000, 5'd8, 5'd7, 5'd6, v);
		imm_op(12'h001, 3'b000, 5'd9, 5'd8, v + 1);
		reg_op(7'h00, 3'b100, 5'd10, 5'd8, 5'd9, v ^ (v + 1));
		reg_op(7'h00, 3'b110, 5'd11, 5'd6, 5'd10, (v + v) | (v ^ (v + 1)));
		imm_op(12'h005, 3'b000, 5'd12, 5'd0, 32'd5);
		imm_op(12'h007, 3'b000, 5'd12, 5'd0, 32'd7);	// Youngest write must win
		reg_op(7'h00, 3'b000, 5'd13, 5'd12, 5'd12, 32'd14);
		run_program("forward");
	endtask

	task automatic test_mem();
		word_t v;
		v = $random(seed) | 32'h8000_8080;		// Negative byte, half and word
		imm_op(12'h100, 3'b000, 5'd20, 5'd0, 32'h100);
		set_reg(5'd21, v);
		emit(s_type(12'd0, 5'd21, 5'd20, 3'b010));	// SW
		emit(s_type(12'd6, 5'd21, 5'd20, 3'b001));	// SH, upper half lanes
		emit(s_type(12'd9, 5'd21, 5'd20, 3'b000));	// SB, lane 1
		load_op(3'b010, 12'd0, 5'd1, v);
		load_op(3'b001, 12'd6, 5'd2, {{16{v[15]}}, v[15:0]});
		load_op(3'b101, 12'd6, 5'd3, {16'b0, v[15:0]});
		load_op(3'b000, 12'd9, 5'd4, {{24{v[7]}}, v[7:0]});
		load_op(3'b100, 12'd9, 5'd5, {24'b0, v[7:0]});
		load_op(3'b000, 12'd3, 5'd6, {{24{v[31]}}, v[31:24]});
		load_op(3'b101, 12'd2, 5'd7, {16'b0, v[31:16]});
		emit(s_type(12'd1, 5'd0, 5'd20, 3'b000));	// Clear one byte of word 0
		load_op(3'b100, 12'd1, 5'd10, 32'd0);
		load_op(3'b010, 12'd0, 5'd11, v & 32'hffff_00ff);
		// Load-use pair, one stall then WB forward
		load_op(3'b010, 12'd0, 5'd8, v & 32'hffff_00ff);
		reg_op(7'h00, 3'b000, 5'd9, 5'd8, 5'd21, (v & 32'hffff_00ff) + v);
		run_program("mem");
	endtask

	task automatic test_branch();
		word_t      r, k;
		word_t      pa [3];
		word_t      pb [3];
		logic [2:0] conds [6];
		bit         taken;
		int         p, c, j;
		r = $random(seed);
		pa = '{r, 32'hffff_fffb, 32'd3};
		pb = '{r, 32'd3, 32'hffff_fffb};
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		k = 32'd1;
		for (p = 0; p < 3; p++) begin
			set_reg(5'd1, pa[p]);
			set_reg(5'd2, pb[p]);
			for (c = 0; c < 6; c++) begin
				taken = branch_taken(conds[c], pa[p], pb[p]);
				emit(b_type(13'd12, 5'd2, 5'd1, conds[c]));	// Skips two words
				for (j = 0; j < 3; j++) begin
					emit(i_type(k[11:0], 5'd0, 3'b000, reg_idx_t'(10 + j), OPC_OPIMM));
					if (!taken || (j == 2))
						want(reg_idx_t'(10 + j), k);
					k = k + 1;
				end
			end
		end
		run_program("branch");
	endtask

	task automatic test_jump();
		word_t p, t, r;
		p = here();
		emit(j_type(21'd12, 5'd1));
		want(5'd1, p + 4);
		imm_op(12'd1, 3'b000, 5'd10, 5'd0, 32'd1);	// Skipped, want entry dropped
		want_rd.delete(want_rd.size() - 1);
		want_data.delete(want_data.size() - 1);
		emit(i_type(12'd2, 5'd0, 3'b000, 5'd11, OPC_OPIMM));
		imm_op(12'd3, 3'b000, 5'd12, 5'd0, 32'd3);
		t = here() + 16;				// JALR landing
		imm_op(t[11:0], 3'b000, 5'd5, 5'd0, t);
		emit(i_type(12'd1, 5'd5, 3'b000, 5'd6, OPC_JALR));	// Odd sum, bit 0 cleared
		want(5'd6, t - 8);
		emit(i_type(12'd5, 5'd0, 3'b000, 5'd10, OPC_OPIMM));
		emit(i_type(12'd6, 5'd0, 3'b000, 5'd11, OPC_OPIMM));
		imm_op(12'd4, 3'b000, 5'd13, 5'd0, 32'd4);
		r = $random(seed);
		emit(u_type(r[31:12], 5'd7, OPC_LUI));
		want(5'd7, {r[31:12], 12'b0});
		p = here();
		emit(u_type(r[19:0], 5'd8, OPC_AUIPC));
		want(5'd8, p + {r[19:0], 12'b0});
		run_program("jump");
	endtask

	initial begin
		arst_n    = 1'b0;
		imem_load = '0;
		test_alu();
		test_forward();
		test_mem();
		test_branch();
		test_jump();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_core.f */
src/rv_core_pkg.sv
src/rv_fetch.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_memory.sv
src/rv_hazard_unit.sv
src/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

/* Makefile */
SIM := obj_dir/Vrv_core_tb

.PHONY: all run clean

all: run

$(SIM): rv_core.f $(wildcard src/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
